//--- verilog/ex_ops_pkg.sv
/*
 * Operation encodings for the execute stage
 *   alu_op_e      ALU result and branch comparison opcodes
 *   mult_op_e     multiplier opcodes, low half and high halves
 *   mult_state_e  multiplier sequencer states
 */

`default_nettype none

package ex_ops_pkg;

  // ALU opcodes
  // First ten produce a result, last six only drive the compare output
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // Branch comparisons
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier opcodes, suffix gives signedness of A and B
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HUU = 2'd3
  } mult_op_e;

  // High-half sequencer
  typedef enum logic {
    MULT_IDLE   = 1'b0,
    MULT_FINISH = 1'b1
  } mult_state_e;

endpackage

`default_nettype wire

//--- verilog/ex_pipe_pkg.sv
/*
 * Pipeline dimensions for the execute stage
 *   datapath and shift-amount widths
 *   register-address width and EX/WB reset value
 */

`default_nettype none

package ex_pipe_pkg;

  // Datapath
  localparam int DATA_W  = 32;
  // Shift amount, low bits of operand B
  localparam int SHAMT_W = 5;

  // Register file address, 6 bits to cover the extended register space
  localparam int RADDR_W = 6;

  // EX/WB address after reset
  localparam logic [RADDR_W-1:0] WADDR_RST = '0;

endpackage

`default_nettype wire

//--- verilog/ex_alu.sv
/*
 * Combinational ALU
 *   add, subtract, logic, shifts, set-less-than
 *   signed and unsigned comparison for branches
 */

`default_nettype none

module ex_alu
  import ex_ops_pkg::*;
  import ex_pipe_pkg::*;
(
  input  alu_op_e             operator_i,
  input  logic [DATA_W-1:0]   operand_a_i,
  input  logic [DATA_W-1:0]   operand_b_i,
  output logic [DATA_W-1:0]   result_o,
  output logic                cmp_result_o
);

  // Shift amount from the low bits of B
  logic [SHAMT_W-1:0] shamt;

  // Comparison flags
  logic is_equal;
  logic is_less_s;
  logic is_less_u;

  assign shamt = operand_b_i[SHAMT_W-1:0];

  //////////////////////////////
  // Comparator
  //////////////////////////////

  assign is_equal  = (operand_a_i == operand_b_i);
  assign is_less_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign is_less_u = (operand_a_i < operand_b_i);

  // Branch decision, SLT/SLTU also report here
  always_comb begin
    cmp_result_o = 1'b0;
    case (operator_i)
      ALU_EQ:   cmp_result_o = is_equal;
      ALU_NE:   cmp_result_o = ~is_equal;
      ALU_LT:   cmp_result_o = is_less_s;
      ALU_GE:   cmp_result_o = ~is_less_s;
      ALU_LTU:  cmp_result_o = is_less_u;
      ALU_GEU:  cmp_result_o = ~is_less_u;
      ALU_SLT:  cmp_result_o = is_less_s;
      ALU_SLTU: cmp_result_o = is_less_u;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Result
  //////////////////////////////

  always_comb begin
    // Comparison opcodes leave the result at zero
    result_o = '0;
    case (operator_i)
      ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      // Shifts
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Set-less-than, zero extended flag
      ALU_SLT:  result_o = {{(DATA_W-1){1'b0}}, is_less_s};
      ALU_SLTU: result_o = {{(DATA_W-1){1'b0}}, is_less_u};
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/ex_mult.sv
/*
 * Integer multiplier
 *   MUL_LO finishes in the issue cycle
 *   high-half products take one extra cycle through a two-state sequencer
 */

`default_nettype none

module ex_mult
  import ex_ops_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_i,
  input  mult_op_e            operator_i,
  input  logic [DATA_W-1:0]   op_a_i,
  input  logic [DATA_W-1:0]   op_b_i,
  input  logic                ex_ready_i,
  output logic [DATA_W-1:0]   result_o,
  output logic                multicycle_o,
  output logic                ready_o
);

  // Operand signedness from the opcode
  logic sign_a;
  logic sign_b;
  logic hi_op;

  // One extra bit per operand covers the mixed-sign case
  logic signed [DATA_W:0]     a_ext;
  logic signed [DATA_W:0]     b_ext;
  logic signed [2*DATA_W+1:0] product;

  mult_state_e       state_q;
  mult_state_e       state_d;
  logic [DATA_W-1:0] hi_q;

  assign sign_a = (operator_i == MUL_HSS) || (operator_i == MUL_HSU);
  assign sign_b = (operator_i == MUL_HSS);
  assign hi_op  = (operator_i != MUL_LO);

  assign a_ext   = $signed({sign_a & op_a_i[DATA_W-1], op_a_i});
  assign b_ext   = $signed({sign_b & op_b_i[DATA_W-1], op_b_i});
  assign product = a_ext * b_ext;

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    // Low half is valid right away
    result_o     = product[DATA_W-1:0];
    case (state_q)
      MULT_IDLE: begin
        if (enable_i && hi_op) begin
          // First cycle, stall while the high half is captured
          ready_o      = 1'b0;
          multicycle_o = 1'b1;
          state_d      = MULT_FINISH;
        end
      end
      MULT_FINISH: begin
        result_o = hi_q;
        // Hold under back-pressure
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // High half of the product, loaded in the first cycle
  always_ff @(posedge clk) begin
    if (multicycle_o) begin
      hi_q <= product[2*DATA_W-1:DATA_W];
    end
  end

endmodule

`default_nettype wire

//--- verilog/ex_writeback.sv
/*
 * Execute stage write-back logic
 *   ALU-port write data select
 *   EX/WB register for the load write port
 *   stage ready/valid
 */

`default_nettype none

module ex_writeback
  import ex_pipe_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                alu_en_i,
  input  logic                mult_en_i,
  input  logic                csr_access_i,
  input  logic                lsu_en_i,
  input  logic [DATA_W-1:0]   alu_result_i,
  input  logic [DATA_W-1:0]   mult_result_i,
  input  logic [DATA_W-1:0]   csr_rdata_i,
  input  logic                mult_ready_i,
  input  logic                lsu_ready_ex_i,
  input  logic                lsu_err_i,
  input  logic                wb_ready_i,
  input  logic                branch_in_ex_i,
  input  logic                regfile_we_i,
  input  logic [RADDR_W-1:0]  regfile_waddr_i,
  output logic [DATA_W-1:0]   regfile_alu_wdata_fw_o,
  output logic                regfile_we_wb_o,
  output logic [RADDR_W-1:0]  regfile_waddr_wb_o,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  // All units done and writeback accepting
  logic units_ready;
  logic stage_valid;
  // Load write enable, dropped on a load error
  logic lsu_we;

  logic               we_q;
  logic [RADDR_W-1:0] waddr_q;

  // ALU port data, CSR over multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign stage_valid = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // A branch finishes in EX without needing writeback
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = stage_valid;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= WADDR_RST;
    end else if (stage_valid) begin
      we_q <= lsu_we;
      // Keep the last address when nothing is written
      if (lsu_we) begin
        waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Bubble, flush the pending write
      we_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;

endmodule

`default_nettype wire

//--- verilog/ex_stage.sv
/*
 * Execute stage top level
 *   ALU, multiplier and write-back instances
 *   branch, load data and ALU-port pass-throughs
 */

`default_nettype none

module ex_stage
  import ex_ops_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  // ALU
  input  logic                alu_en_i,
  input  alu_op_e             alu_operator_i,
  input  logic [DATA_W-1:0]   alu_operand_a_i,
  input  logic [DATA_W-1:0]   alu_operand_b_i,
  input  logic [DATA_W-1:0]   alu_operand_c_i,
  // Multiplier
  input  logic                mult_en_i,
  input  mult_op_e            mult_operator_i,
  input  logic [DATA_W-1:0]   mult_operand_a_i,
  input  logic [DATA_W-1:0]   mult_operand_b_i,
  output logic                mult_multicycle_o,
  // CSR read data
  input  logic                csr_access_i,
  input  logic [DATA_W-1:0]   csr_rdata_i,
  // Load unit
  input  logic                lsu_en_i,
  input  logic                lsu_ready_ex_i,
  input  logic                lsu_err_i,
  input  logic [DATA_W-1:0]   lsu_rdata_i,
  // Register file write requests
  input  logic                regfile_alu_we_i,
  input  logic [RADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic                regfile_we_i,
  input  logic [RADDR_W-1:0]  regfile_waddr_i,
  input  logic                branch_in_ex_i,
  // ALU write port, forwarded
  output logic                regfile_alu_we_fw_o,
  output logic [RADDR_W-1:0]  regfile_alu_waddr_fw_o,
  output logic [DATA_W-1:0]   regfile_alu_wdata_fw_o,
  // Load write port
  output logic                regfile_we_wb_o,
  output logic [RADDR_W-1:0]  regfile_waddr_wb_o,
  output logic [DATA_W-1:0]   regfile_wdata_wb_o,
  // Branch to fetch
  output logic [DATA_W-1:0]   jump_target_o,
  output logic                branch_decision_o,
  // Stall control
  input  logic                wb_ready_i,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  logic [DATA_W-1:0] alu_result;
  logic [DATA_W-1:0] mult_result;
  logic              mult_ready;

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Sequencer advances when the whole stage is ready
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_writeback u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

  //////////////////////////////
  // Pass-throughs
  //////////////////////////////

  // Target computed in decode, carried on operand C
  assign jump_target_o          = alu_operand_c_i;
  assign regfile_wdata_wb_o     = lsu_rdata_i;
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

endmodule

`default_nettype wire

//--- dv/ex_model.svh
/*
 * Reference model for the execute stage
 *   alu_ref   ALU result per opcode
 *   cmp_ref   branch and set-less-than comparison
 *   mult_ref  low or high half of the 64-bit product
 */

`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

function automatic logic [DATA_W-1:0] alu_ref(input alu_op_e op,
                                              input logic [DATA_W-1:0] a,
                                              input logic [DATA_W-1:0] b);
  logic [SHAMT_W-1:0] sh;
  logic [DATA_W-1:0]  msb;
  logic [DATA_W-1:0]  fill;
  sh   = b[SHAMT_W-1:0];
  msb  = {1'b1, {(DATA_W-1){1'b0}}};
  // Sign bits shifted in from the left
  fill = a[DATA_W-1] ? ~({DATA_W{1'b1}} >> sh) : '0;
  case (op)
    ALU_ADD:  return a + b;
    // Two's complement negate and add
    ALU_SUB:  return a + ~b + DATA_W'(1);
    ALU_AND:  return a & b;
    ALU_OR:   return a | b;
    ALU_XOR:  return a ^ b;
    ALU_SLL:  return a << sh;
    ALU_SRL:  return a >> sh;
    ALU_SRA:  return (a >> sh) | fill;
    // Flipping the sign bits turns signed order into unsigned order
    ALU_SLT:  return DATA_W'((a ^ msb) < (b ^ msb));
    ALU_SLTU: return DATA_W'(a < b);
    default:  return '0;
  endcase
endfunction

function automatic logic cmp_ref(input alu_op_e op,
                                 input logic [DATA_W-1:0] a,
                                 input logic [DATA_W-1:0] b);
  logic [DATA_W-1:0] msb;
  logic              lt_s;
  logic              lt_u;
  msb  = {1'b1, {(DATA_W-1){1'b0}}};
  lt_s = (a ^ msb) < (b ^ msb);
  lt_u = a < b;
  case (op)
    ALU_EQ:  return a == b;
    ALU_NE:  return a != b;
    ALU_LT:  return lt_s;
    ALU_GE:  return !lt_s;
    ALU_LTU: return lt_u;
    ALU_GEU: return !lt_u;
    default: return 1'b0;
  endcase
endfunction

// Unsigned product, then subtract 2^32 times the other operand per negative signed operand
function automatic logic [DATA_W-1:0] mult_ref(input mult_op_e op,
                                               input logic [DATA_W-1:0] a,
                                               input logic [DATA_W-1:0] b);
  logic [2*DATA_W-1:0] prod;
  logic [DATA_W-1:0]   hi;
  prod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
  hi   = prod[2*DATA_W-1:DATA_W];
  if ((op == MUL_HSS || op == MUL_HSU) && a[DATA_W-1])
    hi = hi - b;
  if (op == MUL_HSS && b[DATA_W-1])
    hi = hi - a;
  if (op == MUL_LO)
    return prod[DATA_W-1:0];
  return hi;
endfunction

`endif

//--- dv/ex_stage_tb.sv
/*
 * Execute stage testbench
 *   clock, reset, random stimulus on the falling edge
 *   compare process against the reference model
 *   watchdog and closing summary
 */

`default_nettype none

module ex_stage_tb
  import ex_ops_pkg::*;
  import ex_pipe_pkg::*;
();

  localparam int          PERIOD   = 100;
  localparam logic [31:0] SEED     = 32'hf0b03c02;
  localparam int          N_ALU    = 200;
  localparam int          N_CMP    = 60;
  localparam int          N_MUL    = 40;
  localparam int          N_CSR    = 10;
  localparam int          N_LSU    = 20;
  // Reset and back-pressure sequences count as ten more
  localparam int          N_TESTS  = N_ALU + N_CMP + N_MUL + N_CSR + N_LSU + 10;
  localparam int          WATCHDOG = (N_TESTS * 4 + 100) * PERIOD;
  localparam int          ACCEPT_LIMIT = 8;

  logic clk;
  logic rst_n;
  // DUT inputs
  logic alu_en_i, mult_en_i, csr_access_i, lsu_en_i, lsu_ready_ex_i, lsu_err_i;
  logic regfile_alu_we_i, regfile_we_i, branch_in_ex_i, wb_ready_i;
  alu_op_e  alu_operator_i;
  mult_op_e mult_operator_i;
  logic [DATA_W-1:0]  alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  logic [DATA_W-1:0]  mult_operand_a_i, mult_operand_b_i, csr_rdata_i, lsu_rdata_i;
  logic [RADDR_W-1:0] regfile_alu_waddr_i, regfile_waddr_i;
  // DUT outputs
  logic mult_multicycle_o, regfile_alu_we_fw_o, regfile_we_wb_o;
  logic branch_decision_o, ex_ready_o, ex_valid_o;
  logic [DATA_W-1:0]  regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;
  logic [RADDR_W-1:0] regfile_alu_waddr_fw_o, regfile_waddr_wb_o;

  // Expected values for the current cycle, each with its enable
  logic chk_wdata, chk_ready, chk_valid, chk_bdec, chk_mc, chk_we_wb, chk_waddr;
  logic exp_ready, exp_valid, exp_bdec, exp_mc, exp_we_wb;
  logic [DATA_W-1:0]  exp_wdata;
  logic [RADDR_W-1:0] exp_waddr;

  logic [31:0] rng_state = SEED;
  int          errors = 0;

  `include "ex_model.svh"

  ex_stage dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
    errors++;
    $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  // All inputs back to an idle instruction, no checks armed
  task automatic drive_idle();
    {alu_en_i, mult_en_i, csr_access_i, lsu_en_i, lsu_err_i} = '0;
    {regfile_alu_we_i, regfile_we_i, branch_in_ex_i} = '0;
    lsu_ready_ex_i = 1'b1;
    wb_ready_i = 1'b1;
    alu_operator_i = ALU_ADD;
    mult_operator_i = MUL_LO;
    {alu_operand_a_i, alu_operand_b_i, alu_operand_c_i} = '0;
    {mult_operand_a_i, mult_operand_b_i, csr_rdata_i} = '0;
    lsu_rdata_i = rand32();
    regfile_alu_waddr_i = '0;
    regfile_waddr_i = '0;
    {chk_wdata, chk_ready, chk_valid, chk_bdec, chk_mc, chk_we_wb, chk_waddr} = '0;
  endtask

  // Falling edge, then an idle instruction
  task automatic start_cycle();
    @(negedge clk);
    drive_idle();
  endtask

  task automatic expect_hs(input logic ready, input logic valid);
    chk_ready = 1'b1;
    exp_ready = ready;
    chk_valid = 1'b1;
    exp_valid = valid;
  endtask

  // Decode holds the instruction until ex_ready_o is seen at a rising edge
  task automatic wait_accept();
    int n;
    n = 0;
    @(posedge clk);
    while (ex_ready_o !== 1'b1 && n < ACCEPT_LIMIT) begin
      n++;
      @(posedge clk);
    end
    if (ex_ready_o !== 1'b1) begin
      errors++;
      $display("Instruction was never accepted, ex_ready_o stayed low at %0t", $time);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic run_alu(input alu_op_e op);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    a = rand32();
    b = rand32();
    start_cycle();
    alu_en_i = 1'b1;
    alu_operator_i = op;
    alu_operand_a_i = a;
    alu_operand_b_i = b;
    alu_operand_c_i = rand32();
    regfile_alu_we_i = a[0];
    regfile_alu_waddr_i = b[RADDR_W-1:0];
    expect_hs(1'b1, 1'b1);
    chk_wdata = 1'b1;
    exp_wdata = alu_ref(op, a, b);
    wait_accept();
  endtask

  task automatic run_cmp(input alu_op_e op);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] x;
    a = rand32();
    x = rand32();
    // Equal operands half the time so EQ and NE see both outcomes
    b = x[0] ? a : rand32();
    start_cycle();
    alu_en_i = 1'b1;
    branch_in_ex_i = 1'b1;
    alu_operator_i = op;
    alu_operand_a_i = a;
    alu_operand_b_i = b;
    alu_operand_c_i = rand32();
    expect_hs(1'b1, 1'b1);
    chk_bdec = 1'b1;
    exp_bdec = cmp_ref(op, a, b);
    chk_wdata = 1'b1;
    exp_wdata = '0;
    wait_accept();
  endtask

  task automatic run_mult(input mult_op_e op, input logic corner);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    a = corner ? {1'b1, {(DATA_W-1){1'b0}}} : rand32();
    b = corner ? {DATA_W{1'b1}} : rand32();
    start_cycle();
    mult_en_i = 1'b1;
    mult_operator_i = op;
    mult_operand_a_i = a;
    mult_operand_b_i = b;
    regfile_alu_we_i = 1'b1;
    regfile_alu_waddr_i = a[RADDR_W-1:0];
    if (op != MUL_LO) begin
      // One stall cycle while the high half is captured
      expect_hs(1'b0, 1'b0);
      chk_mc = 1'b1;
      exp_mc = 1'b1;
      @(posedge clk);
      @(negedge clk);
    end
    expect_hs(1'b1, 1'b1);
    chk_mc = 1'b1;
    exp_mc = 1'b0;
    chk_wdata = 1'b1;
    exp_wdata = mult_ref(op, a, b);
    wait_accept();
  endtask

  // CSR data wins over both ALU and multiplier
  task automatic run_csr();
    start_cycle();
    csr_access_i = 1'b1;
    csr_rdata_i = rand32();
    alu_en_i = 1'b1;
    alu_operand_a_i = rand32();
    alu_operand_b_i = rand32();
    mult_en_i = 1'b1;
    mult_operand_a_i = rand32();
    mult_operand_b_i = rand32();
    expect_hs(1'b1, 1'b1);
    chk_wdata = 1'b1;
    exp_wdata = csr_rdata_i;
    wait_accept();
  endtask

  task automatic run_load(input logic err);
    logic [DATA_W-1:0] r;
    r = rand32();
    start_cycle();
    lsu_en_i = 1'b1;
    lsu_err_i = err;
    regfile_we_i = 1'b1;
    regfile_waddr_i = r[RADDR_W-1:0];
    expect_hs(1'b1, 1'b1);
    wait_accept();
    // Write port shows the load one cycle later, unless it faulted
    start_cycle();
    chk_we_wb = 1'b1;
    exp_we_wb = !err;
    chk_waddr = !err;
    exp_waddr = r[RADDR_W-1:0];
    @(posedge clk);
  endtask

  task automatic run_backpressure();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    a = rand32();
    b = rand32();
    // Leave a pending load write in EX/WB
    start_cycle();
    lsu_en_i = 1'b1;
    regfile_we_i = 1'b1;
    regfile_waddr_i = 6'h2a;
    expect_hs(1'b1, 1'b1);
    wait_accept();
    // Writeback stalls, register holds
    start_cycle();
    wb_ready_i = 1'b0;
    lsu_en_i = 1'b1;
    regfile_we_i = 1'b1;
    regfile_waddr_i = 6'h15;
    expect_hs(1'b0, 1'b0);
    chk_we_wb = 1'b1;
    exp_we_wb = 1'b1;
    chk_waddr = 1'b1;
    exp_waddr = 6'h2a;
    repeat (3) @(posedge clk);
    // Branch in EX lets decode move on anyway
    @(negedge clk);
    branch_in_ex_i = 1'b1;
    exp_ready = 1'b1;
    @(posedge clk);
    // High multiply parks in MULT_FINISH under back-pressure
    start_cycle();
    mult_en_i = 1'b1;
    mult_operator_i = MUL_HUU;
    mult_operand_a_i = a;
    mult_operand_b_i = b;
    expect_hs(1'b0, 1'b0);
    chk_mc = 1'b1;
    exp_mc = 1'b1;
    @(posedge clk);
    @(negedge clk);
    wb_ready_i = 1'b0;
    exp_mc = 1'b0;
    chk_wdata = 1'b1;
    exp_wdata = mult_ref(MUL_HUU, a, b);
    repeat (2) @(posedge clk);
    @(negedge clk);
    wb_ready_i = 1'b1;
    expect_hs(1'b1, 1'b1);
    wait_accept();
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (chk_wdata && regfile_alu_wdata_fw_o !== exp_wdata)
        report_mismatch("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp_wdata);
      if (chk_ready && ex_ready_o !== exp_ready)
        report_mismatch("ex_ready_o", DATA_W'(ex_ready_o), DATA_W'(exp_ready));
      if (chk_valid && ex_valid_o !== exp_valid)
        report_mismatch("ex_valid_o", DATA_W'(ex_valid_o), DATA_W'(exp_valid));
      if (chk_bdec && branch_decision_o !== exp_bdec)
        report_mismatch("branch_decision_o", DATA_W'(branch_decision_o), DATA_W'(exp_bdec));
      if (chk_mc && mult_multicycle_o !== exp_mc)
        report_mismatch("mult_multicycle_o", DATA_W'(mult_multicycle_o), DATA_W'(exp_mc));
      if (chk_we_wb && regfile_we_wb_o !== exp_we_wb)
        report_mismatch("regfile_we_wb_o", DATA_W'(regfile_we_wb_o), DATA_W'(exp_we_wb));
      if (chk_waddr && regfile_waddr_wb_o !== exp_waddr)
        report_mismatch("regfile_waddr_wb_o", DATA_W'(regfile_waddr_wb_o), DATA_W'(exp_waddr));
      // Pass-throughs hold every cycle
      if (jump_target_o !== alu_operand_c_i)
        report_mismatch("jump_target_o", jump_target_o, alu_operand_c_i);
      if (regfile_wdata_wb_o !== lsu_rdata_i)
        report_mismatch("regfile_wdata_wb_o", regfile_wdata_wb_o, lsu_rdata_i);
      if (regfile_alu_we_fw_o !== regfile_alu_we_i)
        report_mismatch("regfile_alu_we_fw_o", DATA_W'(regfile_alu_we_fw_o),
                        DATA_W'(regfile_alu_we_i));
      if (regfile_alu_waddr_fw_o !== regfile_alu_waddr_i)
        report_mismatch("regfile_alu_waddr_fw_o", DATA_W'(regfile_alu_waddr_fw_o),
                        DATA_W'(regfile_alu_waddr_i));
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG);
    $display("Watchdog expired, the tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n = 1'b0;
    drive_idle();
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (regfile_we_wb_o !== 1'b0)
      report_mismatch("regfile_we_wb_o", DATA_W'(regfile_we_wb_o), '0);
    if (mult_multicycle_o !== 1'b0)
      report_mismatch("mult_multicycle_o", DATA_W'(mult_multicycle_o), '0);
    rst_n = 1'b1;
    // Idle cycle right after reset
    start_cycle();
    chk_we_wb = 1'b1;
    exp_we_wb = 1'b0;
    chk_mc = 1'b1;
    exp_mc = 1'b0;
    @(posedge clk);

    for (int i = 0; i < N_ALU; i++)
      run_alu(alu_op_e'(i % 10));
    for (int i = 0; i < N_CMP; i++)
      run_cmp(alu_op_e'(10 + (rand32() % 6)));
    // Last four multiplies use the most negative and all-ones operands
    for (int i = 0; i < N_MUL; i++)
      run_mult(mult_op_e'(i % 4), i >= N_MUL - 4);
    for (int i = 0; i < N_CSR; i++)
      run_csr();
    for (int i = 0; i < N_LSU; i++)
      run_load(i % 4 == 3);
    run_backpressure();

    start_cycle();
    repeat (2) @(posedge clk);
    $display("Tests done, %0d errors", errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- ex_stage.f
+incdir+dv
verilog/ex_ops_pkg.sv
verilog/ex_pipe_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
dv/ex_stage_tb.sv

//--- Makefile
# Verilator flow for the execute stage
# lint  : lint design and testbench
# sim   : build, run, then search the log for the pass line
# clean : remove build output and log

TOP := ex_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f ex_stage.f --top-module $(TOP)

sim:
	verilator --binary --timing -f ex_stage.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log
